//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_W = 16;  // Data and instruction width
    localparam int REG_AW = 4;   // Register number width

    // Major opcode, top nibble of every instruction
    // Unlisted codes fall through as no-ops
    typedef enum logic [3:0] {
        OP_ALU  = 4'h1,
        OP_LI   = 4'h2,
        OP_LW   = 4'h3,
        OP_SW   = 4'h4,
        OP_BEQ  = 4'h5,
        OP_JMP  = 4'h6,
        OP_HALT = 4'hF
    } opcode_e;

    typedef enum logic [3:0] {
        ADD = 4'h0,
        SUB = 4'h1,
        AND = 4'h2,
        OR  = 4'h3,
        XOR = 4'h4,
        SLT = 4'h5   // Signed less-than, result 0 or 1
    } alu_func_e;

    // Register form: ALU, LI, LW, SW, BEQ
    typedef struct packed {
        opcode_e            op;
        logic [REG_AW-1:0]  r1;   // Dest, also first source
        logic [REG_AW-1:0]  r2;   // Second source, LI imm high nibble
        logic [3:0]         fn;   // ALU func or signed offset
    } instr_reg_t;

    // Jump form
    typedef struct packed {
        opcode_e     op;
        logic [11:0] offset;      // Signed, in instruction words
    } instr_jmp_t;

    typedef union packed {
        instr_reg_t rg;
        instr_jmp_t jmp;
    } instr_u;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,  // Register file value
        FWD_EX  = 2'd1,  // ALU result in execute
        FWD_WB  = 2'd2   // Write value in writeback
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- logic/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

// Stage-one register as seen by execute
interface decode_exec_if;
    logic                          valid;
    cpu_pkg::instr_u               instr;
    logic [cpu_pkg::WORD_W-1:0]    op_a;      // Forwarded r1
    logic [cpu_pkg::WORD_W-1:0]    op_b;      // Forwarded r2
    logic [cpu_pkg::WORD_W-1:0]    imm;
    cpu_pkg::alu_func_e            alu_func;
    logic                          reg_wr;
    logic                          mem_rd;
    logic                          mem_wr;
    logic [cpu_pkg::REG_AW-1:0]    dest;

    modport source (output valid, instr, op_a, op_b, imm, alu_func,
                    reg_wr, mem_rd, mem_wr, dest);
    modport sink (input valid, instr, op_a, op_b, imm, alu_func,
                  reg_wr, mem_rd, mem_wr, dest);
    modport monitor (input valid, reg_wr, mem_rd, dest);   // Hazard view
endinterface

interface exec_wb_if;
    logic                          valid;
    logic [cpu_pkg::WORD_W-1:0]    result;    // ALU value or memory address
    logic [cpu_pkg::WORD_W-1:0]    store_data;
    logic [cpu_pkg::REG_AW-1:0]    dest;
    logic                          reg_wr;
    logic                          mem_rd;
    logic                          mem_wr;

    modport source (output valid, result, store_data, dest, reg_wr, mem_rd, mem_wr);
    modport sink (input valid, result, store_data, dest, reg_wr, mem_rd, mem_wr);
    modport monitor (input valid, reg_wr, dest);
endinterface

module cpu_top #(
    parameter int PROG_AW = 8,
    parameter int DATA_AW = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [PROG_AW-1:0]            prog_addr,
    input  logic [cpu_pkg::WORD_W-1:0]    prog_data,
    output logic                          halted,
    output logic                          reg_wr_en,    // Commit stream
    output logic [cpu_pkg::REG_AW-1:0]    reg_wr_addr,
    output logic [cpu_pkg::WORD_W-1:0]    reg_wr_data,
    output logic                          mem_wr_en,    // Store stream
    output logic [DATA_AW-1:0]            mem_wr_addr,
    output logic [cpu_pkg::WORD_W-1:0]    mem_wr_data
);

    decode_exec_if de_if ();
    exec_wb_if     ew_if ();

    logic [cpu_pkg::WORD_W-1:0] ex_result;

    fetch_decode_stage #(.PROG_AW(PROG_AW)) u_fetch (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .ex_result (ex_result),
        .wb_data   (reg_wr_data),   // Writeback value doubles as commit data
        .wb_dest   (reg_wr_addr),
        .wb_we     (reg_wr_en),
        .ex_bus    (de_if.source),
        .ex_mon    (de_if.monitor),
        .wb_mon    (ew_if.monitor),
        .halted    (halted)
    );

    execute_stage u_exec (
        .clk       (clk),
        .rst       (rst),
        .ex_bus    (de_if.sink),
        .wb_bus    (ew_if.source),
        .ex_result (ex_result)
    );

    writeback_stage #(.DATA_AW(DATA_AW)) u_wb (
        .clk         (clk),
        .rst         (rst),
        .wb_bus      (ew_if.sink),
        .wb_data     (reg_wr_data),
        .wb_dest     (reg_wr_addr),
        .wb_we       (reg_wr_en),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [cpu_pkg::REG_AW-1:0]        ra1,
    input  logic [cpu_pkg::REG_AW-1:0]        ra2,
    input  logic                              we,
    input  logic [cpu_pkg::REG_AW-1:0]        wa,
    input  logic [cpu_pkg::WORD_W-1:0]        wd,
    output logic [cpu_pkg::WORD_W-1:0]        rd1,
    output logic [cpu_pkg::WORD_W-1:0]        rd2
);

    logic [cpu_pkg::WORD_W-1:0] regs [2**cpu_pkg::REG_AW];

    // Plain async reads, no write bypass
    // Same-cycle write is picked up by the WB forward in stage one
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**cpu_pkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;      // All 16 registers writable
        end
    end

endmodule

`default_nettype wire

//--- logic/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  cpu_pkg::instr_u    instr,
    decode_exec_if.monitor     ex_bus,
    exec_wb_if.monitor         wb_bus,
    output cpu_pkg::fwd_sel_e  fwd_a,
    output cpu_pkg::fwd_sel_e  fwd_b,
    output logic               stall
);

    logic use_a;   // Opcode reads r1
    logic use_b;   // Opcode reads r2
    logic ex_wr;
    logic wb_wr;

    assign ex_wr = ex_bus.valid && ex_bus.reg_wr;
    assign wb_wr = wb_bus.valid && wb_bus.reg_wr;

    always_comb begin
        use_a = 1'b0;
        use_b = 1'b0;
        case (instr.rg.op)
            cpu_pkg::OP_ALU, cpu_pkg::OP_SW, cpu_pkg::OP_BEQ: begin
                use_a = 1'b1;
                use_b = 1'b1;
            end
            cpu_pkg::OP_LW: use_b = 1'b1;  // Base only
            default: ;                     // LI, JMP, HALT read nothing
        endcase
    end

    // Youngest producer wins; a load in execute has no value yet
    function automatic cpu_pkg::fwd_sel_e pick_src(input logic [cpu_pkg::REG_AW-1:0] src);
        if (ex_wr && !ex_bus.mem_rd && ex_bus.dest == src)
            return cpu_pkg::FWD_EX;
        else if (wb_wr && wb_bus.dest == src)
            return cpu_pkg::FWD_WB;
        else
            return cpu_pkg::FWD_REG;
    endfunction

    assign fwd_a = pick_src(instr.rg.r1);
    assign fwd_b = pick_src(instr.rg.r2);

    // Load-use, one bubble then the WB forward takes over
    assign stall = ex_wr && ex_bus.mem_rd &&
                   ((use_a && ex_bus.dest == instr.rg.r1) ||
                    (use_b && ex_bus.dest == instr.rg.r2));

endmodule

`default_nettype wire

//--- logic/fetch_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_decode_stage #(
    parameter int PROG_AW = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [PROG_AW-1:0]            prog_addr,
    input  logic [cpu_pkg::WORD_W-1:0]    prog_data,
    input  logic [cpu_pkg::WORD_W-1:0]    ex_result,
    input  logic [cpu_pkg::WORD_W-1:0]    wb_data,
    input  logic [cpu_pkg::REG_AW-1:0]    wb_dest,
    input  logic                          wb_we,
    decode_exec_if.source                 ex_bus,
    decode_exec_if.monitor                ex_mon,
    exec_wb_if.monitor                    wb_mon,
    output logic                          halted
);

    logic [cpu_pkg::WORD_W-1:0] prog_mem [2**PROG_AW];
    logic [cpu_pkg::WORD_W-1:0] pc;       // Byte address, always even
    logic [cpu_pkg::WORD_W-1:0] pc_plus2;
    logic [cpu_pkg::WORD_W-1:0] pc_next;
    logic [cpu_pkg::WORD_W-1:0] br_off;   // Sign-extended word offset
    logic [cpu_pkg::WORD_W-1:0] imm;
    logic [cpu_pkg::WORD_W-1:0] rd1;
    logic [cpu_pkg::WORD_W-1:0] rd2;
    logic [cpu_pkg::WORD_W-1:0] op_a;
    logic [cpu_pkg::WORD_W-1:0] op_b;
    cpu_pkg::instr_u            instr;
    cpu_pkg::fwd_sel_e          fwd_a;
    cpu_pkg::fwd_sel_e          fwd_b;
    logic                       stall;
    logic                       taken;
    logic                       is_halt;
    logic                       issue;    // Real instruction goes downstream
    logic                       dec_reg_wr;
    logic                       dec_mem_rd;
    logic                       dec_mem_wr;

    // Loader only works while the core is held in reset
    always_ff @(posedge clk) begin
        if (prog_we && rst)
            prog_mem[prog_addr] <= prog_data;
    end

    assign instr = prog_mem[pc[PROG_AW:1]];  // Word index from byte PC

    register_file u_regs (
        .clk (clk),
        .rst (rst),
        .ra1 (instr.rg.r1),
        .ra2 (instr.rg.r2),
        .we  (wb_we),
        .wa  (wb_dest),
        .wd  (wb_data),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    hazard_unit u_haz (
        .instr  (instr),
        .ex_bus (ex_mon),
        .wb_bus (wb_mon),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b),
        .stall  (stall)
    );

    function automatic logic [cpu_pkg::WORD_W-1:0] fwd_mux(
        input cpu_pkg::fwd_sel_e          sel,
        input logic [cpu_pkg::WORD_W-1:0] reg_val
    );
        case (sel)
            cpu_pkg::FWD_EX: return ex_result;
            cpu_pkg::FWD_WB: return wb_data;
            default:         return reg_val;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a, rd1);
    assign op_b = fwd_mux(fwd_b, rd2);

    // Control decode
    assign dec_reg_wr = instr.rg.op inside {cpu_pkg::OP_ALU, cpu_pkg::OP_LI, cpu_pkg::OP_LW};
    assign dec_mem_rd = instr.rg.op == cpu_pkg::OP_LW;
    assign dec_mem_wr = instr.rg.op == cpu_pkg::OP_SW;
    assign is_halt    = instr.rg.op == cpu_pkg::OP_HALT;

    // LI takes 8 bits from r2 and fn, LW/SW keep the 4-bit offset
    assign imm = (instr.rg.op == cpu_pkg::OP_LI) ?
                 {{(cpu_pkg::WORD_W-8){instr.rg.r2[3]}}, instr.rg.r2, instr.rg.fn} :
                 {{(cpu_pkg::WORD_W-4){instr.rg.fn[3]}}, instr.rg.fn};

    assign br_off = (instr.jmp.op == cpu_pkg::OP_JMP) ?
                    {{(cpu_pkg::WORD_W-12){instr.jmp.offset[11]}}, instr.jmp.offset} :
                    {{(cpu_pkg::WORD_W-4){instr.rg.fn[3]}}, instr.rg.fn};

    // Branch resolved here so nothing on the wrong path is ever fetched
    assign taken = (instr.rg.op == cpu_pkg::OP_JMP) ||
                   (instr.rg.op == cpu_pkg::OP_BEQ && op_a == op_b);

    assign pc_plus2 = pc + cpu_pkg::WORD_W'(2);
    assign pc_next  = taken ? pc_plus2 + {br_off[cpu_pkg::WORD_W-2:0], 1'b0} : pc_plus2;

    assign issue = !stall && !halted && !is_halt;  // HALT itself becomes a bubble

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (issue)
                pc <= pc_next;   // Holds on stall and once halted
            if (is_halt)
                halted <= 1'b1;  // Sticky until reset
        end
    end

    // Stage register, control half
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_bus.valid  <= 1'b0;
            ex_bus.reg_wr <= 1'b0;
            ex_bus.mem_rd <= 1'b0;
            ex_bus.mem_wr <= 1'b0;
        end else begin
            ex_bus.valid  <= issue;
            ex_bus.reg_wr <= issue && dec_reg_wr;
            ex_bus.mem_rd <= issue && dec_mem_rd;
            ex_bus.mem_wr <= issue && dec_mem_wr;
        end
    end

    // Payload half, don't care under a bubble
    always_ff @(posedge clk) begin
        ex_bus.instr    <= instr;
        ex_bus.op_a     <= op_a;
        ex_bus.op_b     <= op_b;
        ex_bus.imm      <= imm;
        ex_bus.alu_func <= cpu_pkg::alu_func_e'(instr.rg.fn);
        ex_bus.dest     <= instr.rg.r1;
    end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                        clk,
    input  logic                        rst,
    decode_exec_if.sink                 ex_bus,
    exec_wb_if.source                   wb_bus,
    output logic [cpu_pkg::WORD_W-1:0]  ex_result
);

    logic [cpu_pkg::WORD_W-1:0] alu_out;
    logic [cpu_pkg::WORD_W-1:0] a;
    logic [cpu_pkg::WORD_W-1:0] b;

    assign a = ex_bus.op_a;
    assign b = ex_bus.op_b;

    always_comb begin
        case (ex_bus.alu_func)
            cpu_pkg::SUB: alu_out = a - b;
            cpu_pkg::AND: alu_out = a & b;
            cpu_pkg::OR:  alu_out = a | b;
            cpu_pkg::XOR: alu_out = a ^ b;
            cpu_pkg::SLT: alu_out = {{(cpu_pkg::WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
            default:      alu_out = a + b;   // ADD and unused codes
        endcase
    end

    // Also the forward path back into stage one
    always_comb begin
        case (ex_bus.instr.rg.op)
            cpu_pkg::OP_ALU:               ex_result = alu_out;
            cpu_pkg::OP_LI:                ex_result = ex_bus.imm;
            cpu_pkg::OP_LW, cpu_pkg::OP_SW: ex_result = b + ex_bus.imm;  // Base + offset
            default:                       ex_result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_bus.valid  <= 1'b0;
            wb_bus.reg_wr <= 1'b0;
            wb_bus.mem_rd <= 1'b0;
            wb_bus.mem_wr <= 1'b0;
        end else begin
            wb_bus.valid  <= ex_bus.valid;
            wb_bus.reg_wr <= ex_bus.reg_wr;
            wb_bus.mem_rd <= ex_bus.mem_rd;
            wb_bus.mem_wr <= ex_bus.mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        wb_bus.result     <= ex_result;
        wb_bus.store_data <= a;          // SW stores r1
        wb_bus.dest       <= ex_bus.dest;
    end

endmodule

`default_nettype wire

//--- logic/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage #(
    parameter int DATA_AW = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    exec_wb_if.sink                     wb_bus,
    output logic [cpu_pkg::WORD_W-1:0]  wb_data,
    output logic [cpu_pkg::REG_AW-1:0]  wb_dest,
    output logic                        wb_we,
    output logic                        mem_wr_en,
    output logic [DATA_AW-1:0]          mem_wr_addr,
    output logic [cpu_pkg::WORD_W-1:0]  mem_wr_data
);

    logic [cpu_pkg::WORD_W-1:0] data_mem [2**DATA_AW];
    logic [DATA_AW-1:0]         addr;    // Word address, low bits of result

    assign addr = wb_bus.result[DATA_AW-1:0];

    // Store port, also seen at the top
    assign mem_wr_en   = wb_bus.valid && wb_bus.mem_wr;
    assign mem_wr_addr = addr;
    assign mem_wr_data = wb_bus.store_data;

    always_ff @(posedge clk) begin
        if (!rst && mem_wr_en)
            data_mem[addr] <= wb_bus.store_data;
    end

    // Load data or ALU value, also forwarded to stage one
    assign wb_data = wb_bus.mem_rd ? data_mem[addr] : wb_bus.result;
    assign wb_dest = wb_bus.dest;
    assign wb_we   = wb_bus.valid && wb_bus.reg_wr;

endmodule

`default_nettype wire

//--- verif/cpu_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_assertions (
    input logic clk,
    input logic rst,
    input logic prog_we,
    input logic halted,
    input logic reg_wr_en,
    input logic mem_wr_en
);

    // Halt is sticky, only reset clears it
    halted_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else $error("halted fell while reset was low");

    // Program loader is a reset-time port
    load_in_reset: assert property (@(posedge clk) prog_we |-> rst)
        else $error("prog_we high outside reset");

    // One writeback slot, so a commit and a store never share a cycle
    one_write: assert property (@(posedge clk) disable iff (rst) !(reg_wr_en && mem_wr_en))
        else $error("register write and memory write in the same cycle");

endmodule

bind cpu_top cpu_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .halted    (halted),
    .reg_wr_en (reg_wr_en),
    .mem_wr_en (mem_wr_en)
);

`default_nettype wire

//--- verif/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

    localparam int PROG_AW      = 8;
    localparam int DATA_AW      = 8;
    localparam int HALF_PERIOD  = 50;   // 100 ns clock
    localparam int RST_CYCLES   = 10;   // Quiet reset cycles after the load
    localparam int PROG_LEN     = 27;
    localparam int N_COMMIT     = 17;
    localparam int N_STORE      = 2;
    localparam int DRAIN_CYCLES = 8;    // Watch for stray writes after halt
    localparam int WATCHDOG_CYCLES = PROG_LEN + 1 + RST_CYCLES + (PROG_LEN + 20) * 4;

    logic                          clk;
    logic                          rst;
    logic                          prog_we;
    logic [PROG_AW-1:0]            prog_addr;
    logic [cpu_pkg::WORD_W-1:0]    prog_data;
    logic                          halted;
    logic                          reg_wr_en;
    logic [cpu_pkg::REG_AW-1:0]    reg_wr_addr;
    logic [cpu_pkg::WORD_W-1:0]    reg_wr_data;
    logic                          mem_wr_en;
    logic [DATA_AW-1:0]            mem_wr_addr;
    logic [cpu_pkg::WORD_W-1:0]    mem_wr_data;

    logic [15:0] prog [PROG_LEN];
    logic [19:0] exp_commit [N_COMMIT];  // {reg, value}
    logic [23:0] exp_store [N_STORE];    // {word address, value}
    int          commit_idx;
    int          store_idx;

    cpu_top #(.PROG_AW(PROG_AW), .DATA_AW(DATA_AW)) DUT (
        .clk         (clk),
        .rst         (rst),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .halted      (halted),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Program and expected streams, values worked out by hand
    // ALU form is r1 = r1 op r2, SW stores r1 at r2 + offset
    task automatic load_tables();
        prog = '{
            16'h2105,   // LI  r1, 5
            16'h2203,   // LI  r2, 3
            16'h23FE,   // LI  r3, -2
            16'h1120,   // ADD r1, r2       r2 from WB
            16'h1121,   // SUB r1, r2       r1 from EX
            16'h1132,   // AND r1, r3
            16'h1123,   // OR  r1, r2
            16'h1134,   // XOR r1, r3
            16'h1125,   // SLT r1, r2       -7 < 3
            16'h1235,   // SLT r2, r3       3 < -2 is false
            16'h2410,   // LI  r4, 0x10
            16'h252A,   // LI  r5, 0x2A
            16'h4542,   // SW  r5, 2(r4)
            16'h3642,   // LW  r6, 2(r4)
            16'h1650,   // ADD r6, r5       load-use stall
            16'h272A,   // LI  r7, 0x2A
            16'h5751,   // BEQ r7, r5, +1   taken
            16'h2811,   // LI  r8, 0x11     skipped
            16'h5671,   // BEQ r6, r7, +1   not taken
            16'h297F,   // LI  r9, 0x7F
            16'h6002,   // JMP +2
            16'h2A01,   // LI  r10, 1       skipped
            16'h4940,   // SW  r9, 0(r4)    skipped
            16'h2B33,   // LI  r11, 0x33
            16'h4B43,   // SW  r11, 3(r4)
            16'hF000,   // HALT
            16'h2C01    // LI  r12, 1       past the halt
        };
        exp_commit = '{
            20'h1_0005, 20'h2_0003, 20'h3_FFFE,
            20'h1_0008, 20'h1_0005, 20'h1_0004,  // ADD SUB AND
            20'h1_0007, 20'h1_FFF9, 20'h1_0001,  // OR XOR SLT
            20'h2_0000, 20'h4_0010, 20'h5_002A,
            20'h6_002A, 20'h6_0054,               // Load, then dependent ADD
            20'h7_002A, 20'h9_007F, 20'hB_0033
        };
        exp_store = '{24'h12_002A, 24'h13_0033};
    endtask

    // Commit and store monitor, sampled mid-cycle
    initial begin
        commit_idx = 0;
        store_idx  = 0;
        forever begin
            @(negedge clk);
            if (!rst && reg_wr_en) begin
                if (commit_idx >= N_COMMIT) begin
                    check("commit count", 32'(commit_idx + 1), 32'(N_COMMIT));
                end else begin
                    check("commit reg", 32'(reg_wr_addr), 32'(exp_commit[commit_idx][19:16]));
                    check("commit data", 32'(reg_wr_data), 32'(exp_commit[commit_idx][15:0]));
                end
                commit_idx++;
            end
            if (!rst && mem_wr_en) begin
                if (store_idx >= N_STORE) begin
                    check("store count", 32'(store_idx + 1), 32'(N_STORE));
                end else begin
                    check("store addr", 32'(mem_wr_addr), 32'(exp_store[store_idx][23:16]));
                    check("store data", 32'(mem_wr_data), 32'(exp_store[store_idx][15:0]));
                end
                store_idx++;
            end
        end
    end

    // Load time plus four cycles per instruction with slack
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the program did not halt and drain within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        load_tables();

        // Program load, one word per cycle while reset holds the core
        @(posedge clk);
        for (int i = 0; i < PROG_LEN; i++) begin
            #5;
            prog_we   = 1'b1;
            prog_addr = PROG_AW'(i);
            prog_data = prog[i];
            @(posedge clk);
        end
        #5;
        prog_we = 1'b0;

        repeat (RST_CYCLES) @(posedge clk);
        #5;
        rst = 1'b0;
        check("halted after reset", 32'(halted), 32'd0);
        check("reg_wr_en after reset", 32'(reg_wr_en), 32'd0);
        check("mem_wr_en after reset", 32'(mem_wr_en), 32'd0);

        wait (halted === 1'b1);
        repeat (DRAIN_CYCLES) @(posedge clk);   // Older instructions drain, nothing follows
        check("final commit count", 32'(commit_idx), 32'(N_COMMIT));
        check("final store count", 32'(store_idx), 32'(N_STORE));
        check("halted held", 32'(halted), 32'd1);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
logic/cpu_pkg.sv
logic/cpu_top.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/fetch_decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
verif/cpu_assertions.sv
verif/tb_cpu.sv

//--- run.sh
#!/bin/sh
# Builds the CPU testbench with Verilator and runs it
# Exit status is nonzero on a build error or a failed run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_cpu -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit $status
fi

exit 0
